// File: fetch_predictor.f
isa_pkg.sv
predictor_pkg.sv
prediction_counters.sv
btb_table.sv
branch_resolver.sv
program_counter.sv
fetch_predictor.sv
fetch_predictor_tb.sv

// File: Bender.yml
package:
  name: fetch_predictor

sources:
  - isa_pkg.sv
  - predictor_pkg.sv
  - prediction_counters.sv
  - btb_table.sv
  - branch_resolver.sv
  - program_counter.sv
  - fetch_predictor.sv
  - target: simulation
    files:
      - fetch_predictor_tb.sv

// File: fetch_predictor_tb.sv
/*
   fetch predictor testbench
   drives resolved beq/bne/j and ihit stalls into the DUT, keeps its own
   model of the pc and the btb, and checks pc, prediction and flush
   with concurrent assertions
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor_tb
   import isa_pkg::*;
   import predictor_pkg::*;
();

   localparam int    INDEX_BITS  = 2;
   localparam int    ENTRIES     = 1 << INDEX_BITS;
   localparam word_t PC_INIT     = 32'h0000_0000;
   localparam int    WAIT_LIMIT  = 32;   // cycles per wait loop
   localparam int    RAND_CYCLES = 80;
   localparam word_t BR_PC       = 32'h0000_0040;  // beq under test at index 0
   localparam word_t BR_TARGET   = 32'h0000_0084;  // 0x44 + (0x10 << 2)
   localparam word_t BNE_PC      = 32'h0000_0064;  // index 1
   localparam word_t STALL_PC    = 32'h0000_00a0;  // aliases index 0 with another tag

   logic     CLK;
   logic     nRST;
   logic     ihit;
   resolve_t resolve;
   word_t    imem_addr;
   logic     predicted;
   logic     flush;

   logic [31:0] lfsr = 32'hfb7f;
   int          mismatches = 0;
   int          failures = 0;

   // reference model state
   word_t       model_pc;
   logic        m_valid  [ENTRIES];
   word_t       m_tag    [ENTRIES];
   word_t       m_target [ENTRIES];
   logic [1:0]  m_state  [ENTRIES];  // 00 strong taken .. 11 strong not taken

   logic        exp_taken;
   logic        exp_flush;
   logic        exp_pred;
   word_t       exp_btarget;
   word_t       exp_jtarget;
   word_t       exp_redirect;
   word_t       wr_pc;
   int          wi;
   logic        wr_hit;

   fetch_predictor #(
      .INDEX_BITS (INDEX_BITS),
      .PC_INIT    (PC_INIT)
   ) UUT (
      .CLK       (CLK),
      .nRST      (nRST),
      .ihit      (ihit),
      .resolve   (resolve),
      .imem_addr (imem_addr),
      .predicted (predicted),
      .flush     (flush)
   );

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form
   endfunction

   function automatic int index_of(input word_t a);
      return int'(a[2 +: INDEX_BITS]);
   endfunction

   function automatic word_t tag_of(input word_t a);
      return a >> (2 + INDEX_BITS);  // bits above the index
   endfunction

   // model lookup needs valid + tag match + state in the taken half
   function automatic logic entry_predicts(input word_t a);
      int i;
      i = index_of(a);
      return m_valid[i] && (m_tag[i] == tag_of(a)) && !m_state[i][1];
   endfunction

   function automatic instr_u jump_word(input word_t dest);
      instr_u w;
      w.j.opcode = 6'h02;
      w.j.addr   = dest[27:2];
      return w;
   endfunction

   function automatic instr_u branch_word(input logic is_bne, input imm16_t imm);
      instr_u w;
      w.i.opcode = is_bne ? 6'h05 : 6'h04;
      w.i.rs     = '0;
      w.i.rt     = '0;
      w.i.imm    = imm;
      return w;
   endfunction

   // expected outcome of whatever sits on resolve
   assign exp_taken    = (resolve.kind == kind_j) | (resolve.zero ^ (resolve.kind == kind_bne));
   assign exp_btarget  = resolve.pc_plus_4 + ({{16{resolve.instr.i.imm[15]}},
                                               resolve.instr.i.imm} << 2);
   assign exp_jtarget  = {resolve.pc_plus_4[31:28], resolve.instr.j.addr, 2'b00};
   assign exp_flush    = resolve.valid &&
                         ((resolve.kind == kind_j) || (exp_taken != resolve.predicted));
   assign exp_redirect = (resolve.kind == kind_j) ? exp_jtarget :
                         exp_taken ? exp_btarget : resolve.pc_plus_4;

   always_comb
   begin
      wr_pc    = resolve.pc_plus_4 - 32'd4;  // the branch's own pc
      wi       = index_of(wr_pc);
      wr_hit   = m_valid[wi] && (m_tag[wi] == tag_of(wr_pc));
      exp_pred = entry_predicts(model_pc);
   end

   always @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         model_pc <= PC_INIT;
         for (int k = 0; k < ENTRIES; k++)
         begin
            m_valid[k] <= 1'b0;
            m_state[k] <= 2'b11;
         end
      end
      else
      begin
         if (exp_flush)
            model_pc <= exp_redirect;  // loads even with ihit low
         else if (ihit)
            model_pc <= exp_pred ? m_target[index_of(model_pc)] : model_pc + 32'd4;
         if (resolve.valid && (resolve.kind != kind_j) && ihit)
         begin
            if (wr_hit && exp_taken)
               m_state[wi] <= (m_state[wi] == 2'b00) ? 2'b00 : m_state[wi] - 2'd1;
            else if (wr_hit)
               m_state[wi] <= (m_state[wi] == 2'b11) ? 2'b11 : m_state[wi] + 2'd1;
            else
            begin
               m_valid[wi]  <= 1'b1;  // miss allocates strong taken
               m_tag[wi]    <= tag_of(wr_pc);
               m_target[wi] <= exp_btarget;
               m_state[wi]  <= 2'b00;
            end
         end
      end
   end

   pc_check: assert property (@(posedge CLK) disable iff (!nRST) imem_addr == model_pc)
      else
      begin
         mismatches++;
         $display("Mismatch at %0t: imem_addr = %h, expected %h",
                  $time, $sampled(imem_addr), $sampled(model_pc));
      end

   pred_check: assert property (@(posedge CLK) disable iff (!nRST) predicted == exp_pred)
      else
      begin
         mismatches++;
         $display("Mismatch at %0t: predicted = %b, expected %b",
                  $time, $sampled(predicted), $sampled(exp_pred));
      end

   flush_check: assert property (@(posedge CLK) disable iff (!nRST) flush == exp_flush)
      else
      begin
         mismatches++;
         $display("Mismatch at %0t: flush = %b, expected %b",
                  $time, $sampled(flush), $sampled(exp_flush));
      end

   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         v    = {v[6:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);  // one step per bit
      end
   endtask

   task automatic step_cycle(input logic hit);
      ihit    = hit;
      resolve = '0;
      @(posedge CLK);
      #2;
   endtask

   task automatic resolve_cycle(input branch_kind_t kind, input logic zero,
                                input word_t pc4, input instr_u ins, input logic hit);
      resolve_t r;
      r           = '0;
      r.valid     = 1'b1;
      r.kind      = kind;
      r.zero      = zero;
      r.pc_plus_4 = pc4;
      r.instr     = ins;
      r.predicted = entry_predicts(pc4 - 32'd4);  // what fetch saw back then
      resolve     = r;
      ihit        = hit;
      @(posedge CLK);
      #2;
      resolve = '0;
   endtask

   task automatic wait_for_pc(input word_t addr);
      int n;
      n = 0;
      while (imem_addr !== addr && n < WAIT_LIMIT)
      begin
         step_cycle(1'b1);
         n++;
      end
      if (imem_addr !== addr)
      begin
         failures++;
         $display("Timeout at %0t: fetch never reached address %h", $time, addr);
      end
   endtask

   initial
   begin
      logic [7:0] hit_b;
      logic [7:0] zero_b;
      logic [7:0] op_b;
      logic [7:0] sel_b;
      word_t      pc4;
      nRST    = 1'b0;
      ihit    = 1'b0;
      resolve = '0;
      repeat (8) @(posedge CLK);
      #2;
      nRST = 1'b1;

      // plain stepping and stalls
      repeat (3) step_cycle(1'b1);
      repeat (2) step_cycle(1'b0);
      repeat (3) step_cycle(1'b1);

      // j while stalled still redirects
      resolve_cycle(kind_j, 1'b0, 32'h104, jump_word(32'h30), 1'b0);
      step_cycle(1'b0);

      // first taken beq allocates and is then refetched
      resolve_cycle(kind_beq, 1'b1, BR_PC + 4, branch_word(1'b0, 16'h0010), 1'b1);
      resolve_cycle(kind_j, 1'b0, 32'h104, jump_word(BR_PC - 8), 1'b1);
      wait_for_pc(BR_PC);
      wait_for_pc(BR_TARGET);

      // two not taken leave the state weak not taken
      repeat (2) resolve_cycle(kind_beq, 1'b0, BR_PC + 4, branch_word(1'b0, 16'h0010), 1'b1);
      resolve_cycle(kind_j, 1'b0, 32'h104, jump_word(BR_PC - 8), 1'b1);
      wait_for_pc(BR_PC);
      wait_for_pc(BR_PC + 4);

      // bne walks all predicted/taken pairs
      resolve_cycle(kind_bne, 1'b0, BNE_PC + 4, branch_word(1'b1, 16'hfff0), 1'b1);
      resolve_cycle(kind_bne, 1'b0, BNE_PC + 4, branch_word(1'b1, 16'hfff0), 1'b1);
      repeat (3) resolve_cycle(kind_bne, 1'b1, BNE_PC + 4, branch_word(1'b1, 16'hfff0), 1'b1);

      // update under stall must not allocate
      resolve_cycle(kind_beq, 1'b1, STALL_PC + 4, branch_word(1'b0, 16'h0010), 1'b0);
      resolve_cycle(kind_j, 1'b0, 32'h104, jump_word(STALL_PC - 8), 1'b1);
      wait_for_pc(STALL_PC);
      wait_for_pc(STALL_PC + 4);

      // random stalls and resolutions
      for (int c = 0; c < RAND_CYCLES; c++)
      begin
         take_bits(1, hit_b);
         take_bits(1, zero_b);
         take_bits(2, op_b);
         take_bits(2, sel_b);
         pc4 = 32'h44 + sel_b * 32'h24;  // branch pcs 0x40, 0x64, 0x88, 0xac
         case (op_b[1:0])
            2'd1: resolve_cycle(kind_beq, zero_b[0], pc4,
                                branch_word(1'b0, sel_b[0] ? 16'hfff0 : 16'h0010), hit_b[0]);
            2'd2: resolve_cycle(kind_bne, zero_b[0], pc4,
                                branch_word(1'b1, sel_b[0] ? 16'hfff0 : 16'h0010), hit_b[0]);
            2'd3: resolve_cycle(kind_j, 1'b0, pc4, jump_word(32'h30), hit_b[0]);
            default: step_cycle(hit_b[0]);
         endcase
      end

      repeat (4) step_cycle(1'b1);  // last assertions fire
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: fetch_predictor.sv
/*
   fetch predictor top
   pc, btb lookup and mem-stage branch resolution wired together
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_predictor
   import isa_pkg::*;
   import predictor_pkg::*;
#(
   parameter int    INDEX_BITS = BTB_INDEX_BITS,
   parameter word_t PC_INIT    = '0
)
(
   input  logic     CLK,
   input  logic     nRST,
   input  logic     ihit,
   input  resolve_t resolve,
   output word_t    imem_addr,
   output logic     predicted,
   output logic     flush
);

   fetch_t     fetch;
   word_t      redirect_pc;
   btb_write_t btb_write;

   assign predicted = fetch.predicted;  // goes down the pipe with the instr

   program_counter #(
      .PC_INIT(PC_INIT)
   ) pc_reg (
      .CLK         (CLK),
      .nRST        (nRST),
      .ihit        (ihit),
      .flush       (flush),
      .redirect_pc (redirect_pc),
      .fetch       (fetch),
      .pc          (imem_addr)
   );

   btb_table #(
      .INDEX_BITS(INDEX_BITS)
   ) btb (
      .CLK       (CLK),
      .nRST      (nRST),
      .ihit      (ihit),
      .pc        (imem_addr),
      .btb_write (btb_write),
      .fetch     (fetch)
   );

   branch_resolver #(
      .INDEX_BITS(INDEX_BITS)
   ) resolver (
      .resolve     (resolve),
      .flush       (flush),
      .redirect_pc (redirect_pc),
      .btb_write   (btb_write)
   );

endmodule

`default_nettype wire

// File: program_counter.sv
/*
   program counter
   holds the fetch pc, steps one word per ihit, follows the btb target
   when predicted, and takes the redirect from the mem stage on flush
*/
`timescale 1ns/1ps
`default_nettype none

module program_counter
   import isa_pkg::*;
   import predictor_pkg::*;
#(
   parameter word_t PC_INIT = '0
)
(
   input  logic   CLK,
   input  logic   nRST,
   input  logic   ihit,
   input  logic   flush,
   input  word_t  redirect_pc,
   input  fetch_t fetch,
   output word_t  pc
);

   word_t pc_plus_4;
   word_t next_pc;
   logic  pc_en;

   assign pc_plus_4 = pc + WORD_BYTES;

   // flush wins over the prediction
   assign next_pc = flush           ? redirect_pc :
                    fetch.predicted ? fetch.target : pc_plus_4;

   assign pc_en = flush | ihit;  // flush loads even under a stall

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         pc <= PC_INIT;
      else if (pc_en)
         pc <= next_pc;
   end

endmodule

`default_nettype wire

// File: branch_resolver.sv
/*
   branch resolver
   mem-stage outcome for beq, bne and j: taken flag, branch and jump
   targets, flush on j or misprediction, and the btb write request
*/
`timescale 1ns/1ps
`default_nettype none

module branch_resolver
   import isa_pkg::*;
   import predictor_pkg::*;
#(
   parameter int INDEX_BITS = BTB_INDEX_BITS
)
(
   input  resolve_t   resolve,
   output logic       flush,
   output word_t      redirect_pc,
   output btb_write_t btb_write
);

   localparam int TAG_BITS = BTB_LINE_BITS - INDEX_BITS;

   logic  is_branch;
   logic  is_jump;
   logic  taken;
   word_t imm_ext;
   word_t branch_target;
   word_t jump_target;
   word_t branch_pc;

   logic [INDEX_BITS-1:0] wr_index;
   logic [TAG_BITS-1:0]   wr_tag;

   assign is_branch = (resolve.kind == kind_beq) || (resolve.kind == kind_bne);
   assign is_jump   = (resolve.kind == kind_j);

   always_comb
   begin
      case (resolve.kind)
         kind_beq: taken = resolve.zero;
         kind_bne: taken = ~resolve.zero;
         kind_j:   taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // i view for the offset, j view for the word index
   assign imm_ext       = {{14{resolve.instr.i.imm[IMM_BITS-1]}}, resolve.instr.i.imm, 2'b00};
   assign branch_target = resolve.pc_plus_4 + imm_ext;
   assign jump_target   = {resolve.pc_plus_4[WORD_BITS-1 -: 4], resolve.instr.j.addr, 2'b00};

   // j never sits in the btb so always flushes
   assign flush = resolve.valid &&
                  (is_jump || (is_branch && (taken != resolve.predicted)));

   assign redirect_pc = is_jump ? jump_target :
                        taken   ? branch_target : resolve.pc_plus_4;

   // btb keyed on the branch's own pc
   assign branch_pc = resolve.pc_plus_4 - WORD_BYTES;
   assign wr_index  = branch_pc[BTB_OFFSET_BITS +: INDEX_BITS];
   assign wr_tag    = branch_pc[WORD_BITS-1 -: TAG_BITS];

   assign btb_write.valid                    = resolve.valid & is_branch;
   assign btb_write.taken                    = taken;
   assign {btb_write.tag, btb_write.index}   = {wr_tag, wr_index};
   assign btb_write.target                   = branch_target;

endmodule

`default_nettype wire

// File: btb_table.sv
/*
   branch target buffer
   direct mapped valid/tag/target storage with the fetch lookup.
   a resolved branch allocates on a miss or trains the counter on a hit,
   only on an ihit edge
*/
`timescale 1ns/1ps
`default_nettype none

module btb_table
   import isa_pkg::*;
   import predictor_pkg::*;
#(
   parameter int INDEX_BITS = BTB_INDEX_BITS
)
(
   input  logic       CLK,
   input  logic       nRST,
   input  logic       ihit,
   input  word_t      pc,
   input  btb_write_t btb_write,
   output fetch_t     fetch
);

   localparam int ENTRIES  = 1 << INDEX_BITS;
   localparam int TAG_BITS = BTB_LINE_BITS - INDEX_BITS;

   logic [ENTRIES-1:0]    valid_q;
   logic [TAG_BITS-1:0]   tag_mem [ENTRIES];
   word_t                 target_mem [ENTRIES];

   logic [INDEX_BITS-1:0] rd_index;
   logic [TAG_BITS-1:0]   rd_tag;
   pred_state_t           rd_state;
   logic                  rd_hit;

   logic [BTB_LINE_BITS-1:0] wr_line;
   logic [INDEX_BITS-1:0]    wr_index;
   logic [TAG_BITS-1:0]      wr_tag;
   logic                     wr_hit;
   logic                     do_write;
   logic                     allocate;
   logic                     train;

   // fetch lookup
   assign rd_index = pc[BTB_OFFSET_BITS +: INDEX_BITS];
   assign rd_tag   = pc[WORD_BITS-1 -: TAG_BITS];
   assign rd_hit   = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);

   assign fetch.predicted = rd_hit &&
                            (rd_state == strong_taken || rd_state == weak_taken);
   assign fetch.target    = target_mem[rd_index];

   // tag+index together always span the line bits
   assign wr_line  = {btb_write.tag, btb_write.index};
   assign wr_index = wr_line[INDEX_BITS-1:0];
   assign wr_tag   = wr_line[BTB_LINE_BITS-1 -: TAG_BITS];
   assign wr_hit   = valid_q[wr_index] && (tag_mem[wr_index] == wr_tag);

   assign do_write = btb_write.valid & ihit;  // stalled updates are dropped
   assign allocate = do_write & ~wr_hit;
   assign train    = do_write & wr_hit;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         valid_q <= '0;
      else if (allocate)
         valid_q[wr_index] <= 1'b1;
   end

   // tag / target only change on allocate
   always_ff @(posedge CLK)
   begin
      if (allocate)
      begin
         tag_mem[wr_index]    <= wr_tag;
         target_mem[wr_index] <= btb_write.target;
      end
   end

   prediction_counters #(
      .INDEX_BITS(INDEX_BITS)
   ) counters (
      .CLK      (CLK),
      .nRST     (nRST),
      .allocate (allocate),
      .train    (train),
      .taken    (btb_write.taken),
      .rd_index (rd_index),
      .wr_index (wr_index),
      .rd_state (rd_state)
   );

endmodule

`default_nettype wire

// File: prediction_counters.sv
/*
   prediction counters
   one 2-bit saturating predictor per btb entry.
   allocate forces strong taken, train steps one state
*/
`timescale 1ns/1ps
`default_nettype none

module prediction_counters
   import predictor_pkg::*;
#(
   parameter int INDEX_BITS = BTB_INDEX_BITS
)
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  allocate,
   input  logic                  train,
   input  logic                  taken,
   input  logic [INDEX_BITS-1:0] rd_index,
   input  logic [INDEX_BITS-1:0] wr_index,
   output pred_state_t           rd_state
);

   localparam int ENTRIES = 1 << INDEX_BITS;

   pred_state_t state [ENTRIES];

   // one step, saturating at both ends
   function automatic pred_state_t step(input pred_state_t cur, input logic tk);
      pred_state_t nxt;
      nxt = cur;
      case (cur)
         strong_taken:     nxt = tk ? strong_taken   : weak_taken;
         weak_taken:       nxt = tk ? strong_taken   : weak_not_taken;
         weak_not_taken:   nxt = tk ? weak_taken     : strong_not_taken;
         strong_not_taken: nxt = tk ? weak_not_taken : strong_not_taken;
         default:          nxt = strong_not_taken;
      endcase
      return nxt;
   endfunction

   assign rd_state = state[rd_index];  // fetch-side read, same cycle

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < ENTRIES; i++)
            state[i] <= strong_not_taken;
      end
      else if (allocate)
         state[wr_index] <= strong_taken;  // fresh entry starts taken
      else if (train)
         state[wr_index] <= step(state[wr_index], taken);
   end

endmodule

`default_nettype wire

// File: predictor_pkg.sv
/*
   predictor package
   2-bit prediction states, branch kinds, the memory-stage resolve bundle,
   the btb write request and the fetch-side prediction result
*/
`default_nettype none

package predictor_pkg;

   import isa_pkg::*;

   localparam int BTB_OFFSET_BITS = 2;  // byte offset inside a word
   localparam int BTB_INDEX_BITS  = 2;  // default, 4 entries
   localparam int BTB_LINE_BITS   = WORD_BITS - BTB_OFFSET_BITS;
   localparam int BTB_TAG_BITS    = BTB_LINE_BITS - BTB_INDEX_BITS;

   // low half predicts taken
   typedef enum logic [1:0] {
      strong_taken     = 2'b00,
      weak_taken       = 2'b01,
      weak_not_taken   = 2'b10,
      strong_not_taken = 2'b11
   } pred_state_t;

   typedef enum logic [1:0] {
      kind_beq = 2'd0,
      kind_bne = 2'd1,
      kind_j   = 2'd2
   } branch_kind_t;

   // control-flow instr as seen in mem stage
   typedef struct packed {
      logic         valid;
      branch_kind_t kind;
      logic         zero;       // alu zero flag
      logic         predicted;  // fetch-time guess, carried down
      word_t        pc_plus_4;
      instr_u       instr;
   } resolve_t;

   // allocate or train request to the btb
   typedef struct packed {
      logic                      valid;
      logic                      taken;
      logic [BTB_INDEX_BITS-1:0] index;
      logic [BTB_TAG_BITS-1:0]   tag;
      word_t                     target;  // branch target, used on allocate
   } btb_write_t;

   typedef struct packed {
      logic  predicted;
      word_t target;
   } fetch_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
/*
   isa package
   word types, field widths and the two decodings of an instruction word
   (i-type for branches, j-type for jumps)
*/
`default_nettype none

package isa_pkg;

   localparam int WORD_BITS   = 32;
   localparam int OPCODE_BITS = 6;
   localparam int REG_BITS    = 5;
   localparam int IMM_BITS    = 16;
   localparam int ADDR_BITS   = 26;

   typedef logic [WORD_BITS-1:0]   word_t;
   typedef logic [OPCODE_BITS-1:0] opcode_t;
   typedef logic [REG_BITS-1:0]    regbits_t;
   typedef logic [IMM_BITS-1:0]    imm16_t;   // branch offset, in words
   typedef logic [ADDR_BITS-1:0]   addr26_t;  // jump word index

   localparam word_t WORD_BYTES = 32'd4;  // pc step per fetch

   // beq / bne layout
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      imm16_t   imm;
   } itype_t;

   // j layout
   typedef struct packed {
      opcode_t opcode;
      addr26_t addr;
   } jtype_t;

   // same 32 bits, read either way
   typedef union packed {
      itype_t i;
      jtype_t j;
   } instr_u;

endpackage

`default_nettype wire
